// File: source/rtx_pkg.sv
package rtx_pkg;

  // Frame and scene sizes
  localparam int FRAME_WIDTH   = 8;
  localparam int FRAME_HEIGHT  = 4;
  localparam int MAX_NUM_OBJS  = 4;
  localparam int H_BITS        = $clog2(FRAME_WIDTH);
  localparam int V_BITS        = $clog2(FRAME_HEIGHT);
  localparam int OBJ_IDX_BITS  = $clog2(MAX_NUM_OBJS);
  // One more value than slots, so a count of 4 fits
  localparam int NUM_OBJS_BITS = $clog2(MAX_NUM_OBJS + 1);

  // Fixed-point formats
  localparam int COORD_BITS = 12;
  localparam int CHAN_BITS  = 10;
  // Dot products of a coordinate with a center offset, plus headroom
  localparam int DOT_BITS   = 2 * COORD_BITS + 4;

  // Configuration bus
  localparam int CFG_ADDR_BITS = 6;
  localparam int CFG_DATA_BITS = 32;

  // Global registers
  localparam int REG_CAM_X      = 0;
  localparam int REG_CAM_Y      = 1;
  localparam int REG_CAM_Z      = 2;
  localparam int REG_FOCAL      = 3;
  localparam int REG_NUM_OBJS   = 4;
  localparam int REG_BACKGROUND = 5;

  // Sphere records, one block of OBJ_STRIDE words per slot
  localparam int OBJ_BASE   = 8;
  localparam int OBJ_STRIDE = 8;
  localparam int OBJ_CX     = 0;
  localparam int OBJ_CY     = 1;
  localparam int OBJ_CZ     = 2;
  localparam int OBJ_RADIUS = 3;
  localparam int OBJ_COLOR  = 4;

  typedef logic signed [COORD_BITS-1:0]      coord_t;
  typedef logic signed [DOT_BITS-1:0]        dot_t;
  typedef logic signed [2*DOT_BITS-1:0]      wide_t;
  typedef logic [H_BITS-1:0]                 pix_h_t;
  typedef logic [V_BITS-1:0]                 pix_v_t;
  typedef logic [OBJ_IDX_BITS-1:0]           obj_idx_t;
  typedef logic [NUM_OBJS_BITS-1:0]          num_objs_t;
  typedef logic [CFG_ADDR_BITS-1:0]          cfg_addr_t;
  typedef logic [CFG_DATA_BITS-1:0]          cfg_data_t;

  typedef struct packed {
    coord_t x;
    coord_t y;
    coord_t z;
  } vec3_t;

  // Unsigned Q1.9 channels, r in the top bits
  typedef struct packed {
    logic [CHAN_BITS-1:0] r;
    logic [CHAN_BITS-1:0] g;
    logic [CHAN_BITS-1:0] b;
  } color_t;

  typedef struct packed {
    vec3_t                 center;
    logic [COORD_BITS-1:0] radius;
    color_t                color;
  } sphere_t;

  typedef sphere_t [MAX_NUM_OBJS-1:0] sphere_array_t;

  typedef struct packed {
    vec3_t                 pos;
    logic [COORD_BITS-1:0] focal;
  } camera_t;

  typedef struct packed {
    logic      we;
    cfg_addr_t addr;
    cfg_data_t data;
  } cfg_write_t;

  typedef enum logic [1:0] {
    CAST_IDLE,
    CAST_ISSUE,
    CAST_WAIT
  } caster_state_t;

  typedef enum logic {
    TRACE_IDLE,
    TRACE_SCAN
  } tracer_state_t;

endpackage

// File: source/scene_regs.sv
`timescale 1ns/10ps

module scene_regs (
  input  logic                   clk,
  input  logic                   reset,
  input  rtx_pkg::cfg_write_t    cfg,
  input  logic                   busy,
  output rtx_pkg::camera_t       camera,
  output rtx_pkg::num_objs_t     num_objs,
  output rtx_pkg::color_t        background,
  output rtx_pkg::sphere_array_t spheres
);

  rtx_pkg::cfg_addr_t obj_offset;
  rtx_pkg::cfg_addr_t obj_slot;
  rtx_pkg::cfg_addr_t obj_word;
  rtx_pkg::obj_idx_t  obj_idx;
  logic               obj_hit;
  logic               wr_en;

  // Scene is frozen while a frame is rendering
  assign wr_en = cfg.we && !busy;

  // Split a record address into slot and word
  assign obj_offset = cfg.addr - rtx_pkg::cfg_addr_t'(rtx_pkg::OBJ_BASE);
  assign obj_slot   = obj_offset / rtx_pkg::cfg_addr_t'(rtx_pkg::OBJ_STRIDE);
  assign obj_word   = obj_offset % rtx_pkg::cfg_addr_t'(rtx_pkg::OBJ_STRIDE);
  assign obj_idx    = obj_slot[rtx_pkg::OBJ_IDX_BITS-1:0];
  // Addresses past the last slot fall away
  assign obj_hit    = (cfg.addr >= rtx_pkg::cfg_addr_t'(rtx_pkg::OBJ_BASE)) &&
                      (obj_slot < rtx_pkg::cfg_addr_t'(rtx_pkg::MAX_NUM_OBJS));

  always_ff @(posedge clk) begin
    if (reset) begin
      camera     <= '0;
      num_objs   <= '0;
      background <= '0;
      spheres    <= '0;
    end else if (wr_en) begin
      case (cfg.addr)
        rtx_pkg::REG_CAM_X: camera.pos.x <= cfg.data[rtx_pkg::COORD_BITS-1:0];
        rtx_pkg::REG_CAM_Y: camera.pos.y <= cfg.data[rtx_pkg::COORD_BITS-1:0];
        rtx_pkg::REG_CAM_Z: camera.pos.z <= cfg.data[rtx_pkg::COORD_BITS-1:0];
        rtx_pkg::REG_FOCAL: camera.focal <= cfg.data[rtx_pkg::COORD_BITS-1:0];
        rtx_pkg::REG_NUM_OBJS: begin
          // Count saturates at the number of slots
          if (cfg.data > rtx_pkg::cfg_data_t'(rtx_pkg::MAX_NUM_OBJS))
            num_objs <= rtx_pkg::num_objs_t'(rtx_pkg::MAX_NUM_OBJS);
          else
            num_objs <= cfg.data[rtx_pkg::NUM_OBJS_BITS-1:0];
        end
        rtx_pkg::REG_BACKGROUND: background <= cfg.data[3*rtx_pkg::CHAN_BITS-1:0];
        default: begin
          if (obj_hit) begin
            case (obj_word)
              rtx_pkg::OBJ_CX:
                spheres[obj_idx].center.x <= cfg.data[rtx_pkg::COORD_BITS-1:0];
              rtx_pkg::OBJ_CY:
                spheres[obj_idx].center.y <= cfg.data[rtx_pkg::COORD_BITS-1:0];
              rtx_pkg::OBJ_CZ:
                spheres[obj_idx].center.z <= cfg.data[rtx_pkg::COORD_BITS-1:0];
              rtx_pkg::OBJ_RADIUS:
                spheres[obj_idx].radius <= cfg.data[rtx_pkg::COORD_BITS-1:0];
              rtx_pkg::OBJ_COLOR:
                spheres[obj_idx].color <= cfg.data[3*rtx_pkg::CHAN_BITS-1:0];
              // Spare words in a record are not stored
              default: ;
            endcase
          end
        end
      endcase
    end
  end

endmodule

// File: source/ray_caster.sv
`timescale 1ns/10ps

module ray_caster (
  input  logic              clk,
  input  logic              reset,
  input  rtx_pkg::camera_t  camera,
  input  logic              new_ray,
  output logic              busy,
  output logic              ray_valid,
  output rtx_pkg::vec3_t    ray_origin,
  output rtx_pkg::vec3_t    ray_dir,
  output rtx_pkg::pix_h_t   pixel_h,
  output rtx_pkg::pix_v_t   pixel_v,
  output logic              last_pixel
);

  rtx_pkg::caster_state_t state;
  logic                   last_col;

  assign last_col   = (pixel_h == rtx_pkg::pix_h_t'(rtx_pkg::FRAME_WIDTH - 1));
  assign last_pixel = last_col && (pixel_v == rtx_pkg::pix_v_t'(rtx_pkg::FRAME_HEIGHT - 1));

  // One ray per ISSUE cycle
  assign ray_valid = (state == rtx_pkg::CAST_ISSUE);
  assign busy      = (state != rtx_pkg::CAST_IDLE);

  // Primary ray from the camera through the pixel
  assign ray_origin = camera.pos;
  // Centered on the optical axis, odd steps of 2
  assign ray_dir.x = rtx_pkg::coord_t'({pixel_h, 1'b0}) -
                     rtx_pkg::coord_t'(rtx_pkg::FRAME_WIDTH - 1);
  assign ray_dir.y = rtx_pkg::coord_t'({pixel_v, 1'b0}) -
                     rtx_pkg::coord_t'(rtx_pkg::FRAME_HEIGHT - 1);
  assign ray_dir.z = camera.focal;

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= rtx_pkg::CAST_IDLE;
      pixel_h <= '0;
      pixel_v <= '0;
    end else begin
      case (state)
        rtx_pkg::CAST_IDLE: begin
          // Start pulse opens a frame at the top left
          if (new_ray) begin
            pixel_h <= '0;
            pixel_v <= '0;
            state   <= rtx_pkg::CAST_ISSUE;
          end
        end
        rtx_pkg::CAST_ISSUE: state <= rtx_pkg::CAST_WAIT;
        rtx_pkg::CAST_WAIT: begin
          // Here new_ray is the tracer finishing the current pixel
          if (new_ray) begin
            if (last_pixel) begin
              state <= rtx_pkg::CAST_IDLE;
            end else begin
              state <= rtx_pkg::CAST_ISSUE;
              if (last_col) begin
                pixel_h <= '0;
                pixel_v <= pixel_v + 1'b1;
              end else begin
                pixel_h <= pixel_h + 1'b1;
              end
            end
          end
        end
        default: state <= rtx_pkg::CAST_IDLE;
      endcase
    end
  end

endmodule

// File: source/ray_tracer.sv
`timescale 1ns/10ps

module ray_tracer (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   ray_valid,
  input  rtx_pkg::vec3_t         ray_origin,
  input  rtx_pkg::vec3_t         ray_dir,
  input  rtx_pkg::pix_h_t        pixel_h_in,
  input  rtx_pkg::pix_v_t        pixel_v_in,
  input  logic                   last_in,
  input  rtx_pkg::num_objs_t     num_objs,
  input  rtx_pkg::sphere_array_t spheres,
  input  rtx_pkg::color_t        background,
  output logic                   ray_done,
  output rtx_pkg::color_t        color,
  output rtx_pkg::pix_h_t        pixel_h_out,
  output rtx_pkg::pix_v_t        pixel_v_out,
  output logic                   last_out
);

  rtx_pkg::tracer_state_t state;
  rtx_pkg::obj_idx_t      obj_idx;
  rtx_pkg::vec3_t         org_q;
  rtx_pkg::vec3_t         dir_q;
  rtx_pkg::sphere_t       cur;
  logic                   found;
  logic                   last_obj;
  logic                   cur_hit;
  logic                   capture;

  // Center offset needs one bit more than a coordinate
  logic signed [rtx_pkg::COORD_BITS:0] oc_x;
  logic signed [rtx_pkg::COORD_BITS:0] oc_y;
  logic signed [rtx_pkg::COORD_BITS:0] oc_z;
  logic [2*rtx_pkg::COORD_BITS-1:0]    r_sq;
  rtx_pkg::dot_t                       b_dot;
  rtx_pkg::dot_t                       a_dot;
  rtx_pkg::dot_t                       oc_sq;
  rtx_pkg::dot_t                       q_term;
  rtx_pkg::wide_t                      b_sq;
  rtx_pkg::wide_t                      a_q;

  assign capture  = (state == rtx_pkg::TRACE_IDLE) && ray_valid;
  assign cur      = spheres[obj_idx];
  assign last_obj = (rtx_pkg::num_objs_t'(obj_idx) == num_objs - 1'b1);

  // Discriminant test, all in integers
  assign oc_x   = cur.center.x - org_q.x;
  assign oc_y   = cur.center.y - org_q.y;
  assign oc_z   = cur.center.z - org_q.z;
  assign b_dot  = dir_q.x * oc_x + dir_q.y * oc_y + dir_q.z * oc_z;
  assign a_dot  = dir_q.x * dir_q.x + dir_q.y * dir_q.y + dir_q.z * dir_q.z;
  assign oc_sq  = oc_x * oc_x + oc_y * oc_y + oc_z * oc_z;
  assign r_sq   = cur.radius * cur.radius;
  assign q_term = oc_sq - rtx_pkg::dot_t'(r_sq);
  assign b_sq   = b_dot * b_dot;
  assign a_q    = a_dot * q_term;
  // Sphere must lie ahead of the camera
  assign cur_hit = (b_dot > 0) && (b_sq >= a_q);

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= rtx_pkg::TRACE_IDLE;
      ray_done <= 1'b0;
      obj_idx  <= '0;
      found    <= 1'b0;
    end else begin
      ray_done <= 1'b0;
      case (state)
        rtx_pkg::TRACE_IDLE: begin
          if (ray_valid) begin
            obj_idx <= '0;
            found   <= 1'b0;
            // Empty scene finishes straight away
            if (num_objs == '0)
              ray_done <= 1'b1;
            else
              state <= rtx_pkg::TRACE_SCAN;
          end
        end
        rtx_pkg::TRACE_SCAN: begin
          if (cur_hit)
            found <= 1'b1;
          if (last_obj) begin
            ray_done <= 1'b1;
            state    <= rtx_pkg::TRACE_IDLE;
          end else begin
            obj_idx <= obj_idx + 1'b1;
          end
        end
        default: state <= rtx_pkg::TRACE_IDLE;
      endcase
    end
  end

  // Ray, coordinates and running color
  always_ff @(posedge clk) begin
    if (capture) begin
      org_q       <= ray_origin;
      dir_q       <= ray_dir;
      pixel_h_out <= pixel_h_in;
      pixel_v_out <= pixel_v_in;
      last_out    <= last_in;
      color       <= background;
    end else if (state == rtx_pkg::TRACE_SCAN && cur_hit && !found) begin
      // Lowest index wins, later hits are dropped
      color <= cur.color;
    end
  end

endmodule

// File: source/color_convert.sv
`timescale 1ns/10ps

module color_convert (
  input  logic            clk,
  input  logic            reset,
  input  logic            ray_done,
  input  rtx_pkg::color_t color,
  input  rtx_pkg::pix_h_t pixel_h_in,
  input  rtx_pkg::pix_v_t pixel_v_in,
  input  logic            last_in,
  output logic [15:0]     pixel,
  output rtx_pkg::pix_h_t pixel_h,
  output rtx_pkg::pix_v_t pixel_v,
  output logic            pixel_valid,
  output logic            frame_done
);

  logic [5:0] r6;
  logic [5:0] g6;
  logic [5:0] b6;

  // Top six fraction bits, or all ones at 1.0 and above
  function automatic logic [5:0] sat_chan(input logic [rtx_pkg::CHAN_BITS-1:0] c);
    if (c[rtx_pkg::CHAN_BITS-1])
      return '1;
    return c[rtx_pkg::CHAN_BITS-2 -: 6];
  endfunction

  assign r6 = sat_chan(color.r);
  assign g6 = sat_chan(color.g);
  assign b6 = sat_chan(color.b);

  always_ff @(posedge clk) begin
    if (reset) begin
      pixel_valid <= 1'b0;
      frame_done  <= 1'b0;
    end else begin
      pixel_valid <= ray_done;
      frame_done  <= ray_done && last_in;
    end
  end

  // 5-bit fields are the top of the 6-bit result
  always_ff @(posedge clk) begin
    if (ray_done) begin
      pixel   <= {b6[5:1], g6, r6[5:1]};
      pixel_h <= pixel_h_in;
      pixel_v <= pixel_v_in;
    end
  end

endmodule

// File: source/rtx_top.sv
`timescale 1ns/10ps

module rtx_top (
  input  logic                clk,
  input  logic                reset,
  input  rtx_pkg::cfg_write_t cfg,
  input  logic                start,
  output logic [15:0]         pixel,
  output rtx_pkg::pix_h_t     pixel_h,
  output rtx_pkg::pix_v_t     pixel_v,
  output logic                pixel_valid,
  output logic                frame_done
);

  rtx_pkg::camera_t       camera;
  rtx_pkg::num_objs_t     num_objs;
  rtx_pkg::color_t        background;
  rtx_pkg::sphere_array_t spheres;

  logic                   busy;
  logic                   new_ray;
  logic                   ray_valid;
  rtx_pkg::vec3_t         ray_origin;
  rtx_pkg::vec3_t         ray_dir;
  rtx_pkg::pix_h_t        cast_h;
  rtx_pkg::pix_v_t        cast_v;
  logic                   cast_last;

  logic                   ray_done;
  rtx_pkg::color_t        trace_color;
  rtx_pkg::pix_h_t        trace_h;
  rtx_pkg::pix_v_t        trace_v;
  logic                   trace_last;

  // Next ray on start or when the previous one is traced
  // Start is dropped while a frame is running
  assign new_ray = (start && !busy) || ray_done;

  scene_regs u_regs (
    .clk        (clk),
    .reset      (reset),
    .cfg        (cfg),
    .busy       (busy),
    .camera     (camera),
    .num_objs   (num_objs),
    .background (background),
    .spheres    (spheres)
  );

  ray_caster u_caster (
    .clk        (clk),
    .reset      (reset),
    .camera     (camera),
    .new_ray    (new_ray),
    .busy       (busy),
    .ray_valid  (ray_valid),
    .ray_origin (ray_origin),
    .ray_dir    (ray_dir),
    .pixel_h    (cast_h),
    .pixel_v    (cast_v),
    .last_pixel (cast_last)
  );

  ray_tracer u_tracer (
    .clk         (clk),
    .reset       (reset),
    .ray_valid   (ray_valid),
    .ray_origin  (ray_origin),
    .ray_dir     (ray_dir),
    .pixel_h_in  (cast_h),
    .pixel_v_in  (cast_v),
    .last_in     (cast_last),
    .num_objs    (num_objs),
    .spheres     (spheres),
    .background  (background),
    .ray_done    (ray_done),
    .color       (trace_color),
    .pixel_h_out (trace_h),
    .pixel_v_out (trace_v),
    .last_out    (trace_last)
  );

  // One register stage to RGB565
  color_convert u_convert (
    .clk         (clk),
    .reset       (reset),
    .ray_done    (ray_done),
    .color       (trace_color),
    .pixel_h_in  (trace_h),
    .pixel_v_in  (trace_v),
    .last_in     (trace_last),
    .pixel       (pixel),
    .pixel_h     (pixel_h),
    .pixel_v     (pixel_v),
    .pixel_valid (pixel_valid),
    .frame_done  (frame_done)
  );

endmodule

// File: verif/rtx_props.sv
`timescale 1ns/10ps

module rtx_props (
  input logic            clk,
  input logic            reset,
  input logic            busy,
  input logic            ray_done,
  input logic            pixel_valid,
  input logic            frame_done,
  input rtx_pkg::pix_h_t pixel_h,
  input rtx_pkg::pix_v_t pixel_v
);

  rtx_pkg::pix_h_t next_h;
  rtx_pkg::pix_v_t next_v;

  // Raster position the next pixel has to carry
  // Wraps to the top left after the last pixel of a frame
  always_ff @(posedge clk) begin
    if (reset) begin
      next_h <= '0;
      next_v <= '0;
    end else if (pixel_valid) begin
      {next_v, next_h} <= {pixel_v, pixel_h} + 1'b1;
    end
  end

  // Pixels are at least two cycles apart
  a_pixel_gap: assert property (@(posedge clk) disable iff (reset)
    pixel_valid |=> !pixel_valid)
    else $error("pixel_valid high in two consecutive cycles");

  // End of frame rides on the last pixel strobe with the caster idle again
  a_frame_done: assert property (@(posedge clk) disable iff (reset)
    frame_done |-> pixel_valid && !busy)
    else $error("frame_done without pixel_valid or with the caster still busy");

  // Coordinates walk the raster and never leave the frame
  a_coord_range: assert property (@(posedge clk) disable iff (reset)
    pixel_valid |-> (pixel_h == next_h) && (pixel_v == next_v))
    else $error("pixel coordinates out of raster order");

  // A traced ray belongs to a running frame
  // One register stage in the converter
  a_convert_latency: assert property (@(posedge clk) disable iff (reset)
    ray_done |=> pixel_valid && $past(busy))
    else $error("ray_done outside a frame or not followed by pixel_valid");

endmodule

bind rtx_top rtx_props u_props (
  .clk         (clk),
  .reset       (reset),
  .busy        (busy),
  .ray_done    (ray_done),
  .pixel_valid (pixel_valid),
  .frame_done  (frame_done),
  .pixel_h     (pixel_h),
  .pixel_v     (pixel_v)
);

// File: verif/rtx_tb.sv
`timescale 1ns/10ps

module rtx_tb;

  localparam int HALF_PERIOD  = 50;
  localparam int RESET_CYCLES = 10;
  localparam int FRAME_PIXELS = rtx_pkg::FRAME_WIDTH * rtx_pkg::FRAME_HEIGHT;
  localparam rtx_pkg::pix_h_t LAST_H = rtx_pkg::pix_h_t'(rtx_pkg::FRAME_WIDTH - 1);
  localparam rtx_pkg::pix_v_t LAST_V = rtx_pkg::pix_v_t'(rtx_pkg::FRAME_HEIGHT - 1);

  logic                clk;
  logic                reset;
  rtx_pkg::cfg_write_t cfg;
  logic                start;
  logic [15:0]         pixel;
  rtx_pkg::pix_h_t     pixel_h;
  rtx_pkg::pix_v_t     pixel_v;
  logic                pixel_valid;
  logic                frame_done;

  // Write, start and during-frame records in file order
  logic [7:0]      rec_kind[$];
  int unsigned     rec_a[$];
  int unsigned     rec_b[$];
  // Expected pixels in arrival order
  rtx_pkg::pix_h_t exp_h[$];
  rtx_pkg::pix_v_t exp_v[$];
  logic [15:0]     exp_pix[$];

  int cycle          = 0;
  int next_pix_cycle = 0;
  int pix_period     = 0;
  int frames         = 0;
  int pixels_seen    = 0;
  int limit_cycles   = 0;
  int value_errors   = 0;
  int timing_errors  = 0;
  int count_errors   = 0;

  rtx_top u_dut (
    .clk         (clk),
    .reset       (reset),
    .cfg         (cfg),
    .start       (start),
    .pixel       (pixel),
    .pixel_h     (pixel_h),
    .pixel_v     (pixel_v),
    .pixel_valid (pixel_valid),
    .frame_done  (frame_done)
  );

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  task automatic load_golden(output bit ok);
    int          fd;
    int          col;
    int unsigned a;
    int unsigned b;
    logic [63:0] tok;
    string       line;
    ok = 1'b1;
    fd = $fopen("verif/rtx_golden.txt", "r");
    if (fd == 0) begin
      $display("Cannot open verif/rtx_golden.txt");
      ok = 1'b0;
    end else begin
      while ($fscanf(fd, "%s", tok) == 1) begin
        if (tok[7:0] == "#") begin
          void'($fgets(line, fd));
        end else if (tok[7:0] == "W" || tok[7:0] == "D") begin
          void'($fscanf(fd, "%h %h", a, b));
          rec_kind.push_back(tok[7:0]);
          rec_a.push_back(a);
          rec_b.push_back(b);
        end else if (tok[7:0] == "S") begin
          void'($fscanf(fd, "%d", a));
          rec_kind.push_back(tok[7:0]);
          rec_a.push_back(a);
          rec_b.push_back(0);
          frames++;
        end else if (tok[7:0] == "R") begin
          // Row number, then one pixel per column
          void'($fscanf(fd, "%d", a));
          for (col = 0; col < rtx_pkg::FRAME_WIDTH; col++) begin
            void'($fscanf(fd, "%h", b));
            exp_h.push_back(rtx_pkg::pix_h_t'(col));
            exp_v.push_back(rtx_pkg::pix_v_t'(a));
            exp_pix.push_back(b[15:0]);
          end
        end else begin
          $display("Unknown record in the golden file");
          count_errors++;
        end
      end
      $fclose(fd);
    end
  endtask

  // One write cycle on the config port
  task automatic write_reg(input int unsigned addr, input int unsigned data);
    @(posedge clk);
    cfg.we   <= 1'b1;
    cfg.addr <= rtx_pkg::cfg_addr_t'(addr);
    cfg.data <= data;
    @(posedge clk);
    cfg.we <= 1'b0;
  endtask

  task automatic pulse_start();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic wait_frame_end();
    do @(posedge clk); while (!frame_done);
    @(posedge clk);
  endtask

  task automatic finish_run();
    $display("Errors: %0d value, %0d timing, %0d count",
             value_errors, timing_errors, count_errors);
    if (value_errors + timing_errors + count_errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  endtask

  // Checker for every pixel strobe
  always @(posedge clk) begin : check_pixels
    rtx_pkg::pix_h_t eh;
    rtx_pkg::pix_v_t ev;
    logic [15:0]     ep;
    logic            elast;
    if (!reset && frame_done && !pixel_valid) begin
      $display("Error at %0t: frame_done raised without a pixel", $time);
      timing_errors++;
    end
    if (!reset && pixel_valid) begin
      if (exp_pix.size() == 0) begin
        $display("Error at %0t: extra pixel beyond the golden records", $time);
        count_errors++;
      end else begin
        eh    = exp_h.pop_front();
        ev    = exp_v.pop_front();
        ep    = exp_pix.pop_front();
        elast = (eh == LAST_H) && (ev == LAST_V);
        pixels_seen++;
        // First pixel at N+3 after start, then every N+2
        if (cycle != next_pix_cycle) begin
          $display("Fail at %0t: pixel_valid cycle expected %0d got %0d",
                   $time, next_pix_cycle, cycle);
          timing_errors++;
        end
        next_pix_cycle = cycle + pix_period;
        if (pixel !== ep) begin
          $display("Fail at %0t: pixel expected %h got %h", $time, ep, pixel);
          value_errors++;
        end
        if (pixel_h !== eh) begin
          $display("Fail at %0t: pixel_h expected %0d got %0d", $time, eh, pixel_h);
          value_errors++;
        end
        if (pixel_v !== ev) begin
          $display("Fail at %0t: pixel_v expected %0d got %0d", $time, ev, pixel_v);
          value_errors++;
        end
        if (frame_done !== elast) begin
          $display("Fail at %0t: frame_done expected %b got %b", $time, elast, frame_done);
          value_errors++;
        end
      end
    end
  end

  initial begin : watchdog
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("Timeout after %0d cycles, the frames did not finish", limit_cycles);
    count_errors++;
    finish_run();
  end

  initial begin : stimulus
    int i;
    int n_exp;
    int frames_run;
    bit ok;
    reset      = 1'b1;
    start      = 1'b0;
    cfg        = '0;
    frames_run = 0;
    load_golden(ok);
    if (!ok) begin
      count_errors++;
      finish_run();
    end else begin
      // Eight cycles per pixel covers N = 4 with room to spare
      limit_cycles = RESET_CYCLES + frames * FRAME_PIXELS * 8 + 4 * rec_kind.size() + 100;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
      i = 0;
      while (i < rec_kind.size()) begin
        if (rec_kind[i] == "S") begin
          n_exp = int'(rec_a[i]);
          i++;
          @(posedge clk);
          start          <= 1'b1;
          pix_period     = n_exp + 2;
          next_pix_cycle = cycle + n_exp + 4;
          @(posedge clk);
          start <= 1'b0;
          // These land while busy and must not reach the scene
          while (i < rec_kind.size() && rec_kind[i] == "D") begin
            write_reg(rec_a[i], rec_b[i]);
            i++;
          end
          // Second start inside the frame is dropped
          pulse_start();
          wait_frame_end();
          frames_run++;
          if (pixels_seen != frames_run * FRAME_PIXELS) begin
            $display("Frame %0d ended after %0d pixels in total, %0d expected",
                     frames_run, pixels_seen, frames_run * FRAME_PIXELS);
            count_errors++;
          end
        end else begin
          write_reg(rec_a[i], rec_b[i]);
          i++;
        end
      end
      repeat (8) @(posedge clk);
      if (exp_pix.size() != 0) begin
        $display("%0d expected pixels never arrived", exp_pix.size());
        count_errors++;
      end
      finish_run();
    end
  end

endmodule

// File: verif/rtx_golden.txt
# W addr data = write before a frame, D addr data = write while the frame runs
# S num_objs = start with expected N, R row p0..p7 = expected pixels in hex
W 03 00000008
W 05 100203FF
S 0
R 0 FA10 FA10 FA10 FA10 FA10 FA10 FA10 FA10
R 1 FA10 FA10 FA10 FA10 FA10 FA10 FA10 FA10
R 2 FA10 FA10 FA10 FA10 FA10 FA10 FA10 FA10
R 3 FA10 FA10 FA10 FA10 FA10 FA10 FA10 FA10
W 0A 00000028
W 0B 00000014
W 0C 20029D55
W 04 00000001
S 1
R 0 FA10 FA10 AA9F AA9F AA9F AA9F FA10 FA10
R 1 FA10 FA10 AA9F AA9F AA9F AA9F FA10 FA10
R 2 FA10 FA10 AA9F AA9F AA9F AA9F FA10 FA10
R 3 FA10 FA10 AA9F AA9F AA9F AA9F FA10 FA10
W 10 00000010
W 12 00000028
W 13 00000012
W 14 20F3FDFF
W 04 00000002
S 2
R 0 FA10 FA10 AA9F AA9F AA9F AA9F FBFF FA10
R 1 FA10 FA10 AA9F AA9F AA9F AA9F FBFF FBFF
R 2 FA10 FA10 AA9F AA9F AA9F AA9F FBFF FBFF
R 3 FA10 FA10 AA9F AA9F AA9F AA9F FBFF FA10
W 1A 00000FD8
W 1B 00000014
W 1C 3FF00000
W 04 00000003
S 3
R 0 FA10 FA10 AA9F AA9F AA9F AA9F FBFF FA10
R 1 FA10 FA10 AA9F AA9F AA9F AA9F FBFF FBFF
R 2 FA10 FA10 AA9F AA9F AA9F AA9F FBFF FBFF
R 3 FA10 FA10 AA9F AA9F AA9F AA9F FBFF FA10
W 20 00000FF0
W 22 00000028
W 23 00000012
W 24 0F804008
W 04 00000007
S 4
D 05 00000000
D 04 00000000
R 0 FA10 004F AA9F AA9F AA9F AA9F FBFF FA10
R 1 004F 004F AA9F AA9F AA9F AA9F FBFF FBFF
R 2 004F 004F AA9F AA9F AA9F AA9F FBFF FBFF
R 3 FA10 004F AA9F AA9F AA9F AA9F FBFF FA10
W 05 00000000
W 04 00000000
S 0
R 0 0000 0000 0000 0000 0000 0000 0000 0000
R 1 0000 0000 0000 0000 0000 0000 0000 0000
R 2 0000 0000 0000 0000 0000 0000 0000 0000
R 3 0000 0000 0000 0000 0000 0000 0000 0000

// File: rtx.f
source/rtx_pkg.sv
source/scene_regs.sv
source/ray_caster.sv
source/ray_tracer.sv
source/color_convert.sv
source/rtx_top.sv
verif/rtx_props.sv
verif/rtx_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := rtx_tb
FILELIST   := rtx.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
PASS_MSG   := Simulation completed successfully

.PHONY: all build run lint clean

# Build, run and check the result
all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the search for the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
